/* project.f */
verilog/lspcPkg.sv
verilog/vramPortIf.sv
verilog/lspcRegs.sv
verilog/lspcVram.sv
verilog/lspcRaster.sv
verilog/lspcIrq.sv
verilog/lspcTop.sv
test/lspcClock.sv
test/lspcTb_chk.sv
test/lspcTb.sv

/* Bender.yml */
package:
  name: lspc

sources:
  - verilog/lspcPkg.sv
  - verilog/vramPortIf.sv
  - verilog/lspcRegs.sv
  - verilog/lspcVram.sv
  - verilog/lspcRaster.sv
  - verilog/lspcIrq.sv
  - verilog/lspcTop.sv
  - target: test
    files:
      - test/lspcClock.sv
      - test/lspcTb_chk.sv
      - test/lspcTb.sv

/* test/lspcTb.sv */
`timescale 1ns/10ps
`default_nettype none

module lspcTb;

	localparam int VRAM_AW     = 8;
	localparam int PIXEL_DIV   = 4;
	localparam int LINE_PIXELS = 4;
	localparam int FRAME_LINES = 24;
	localparam int VBLANK_LINE = 20;
	localparam int FRAME_CLKS  = PIXEL_DIV * LINE_PIXELS * FRAME_LINES;
	localparam int TICK_LIMIT  = 6 * PIXEL_DIV + 8;	// Six pixel ticks plus margin
	localparam int LVL_LIMIT   = FRAME_CLKS + 16;

	typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_WAIT_LEVEL, OP_WAIT_CYCLES} stepOp_e;

	logic        CLK_24M;
	logic        nRESET;
	logic        cpuValid;
	logic        cpuWrite;
	logic [2:0]  cpuAddr;
	logic [15:0] cpuWrData;
	logic        cpuReady;
	logic        cpuRdValid;
	logic [15:0] cpuRdData;
	logic [1:0]  irqLevel;
	logic [8:0]  vcount;

	// Step table, one entry per index
	string       stepName[$];
	stepOp_e     stepOp[$];
	logic [2:0]  stepOff[$];
	logic [15:0] stepData[$];	// Write data, level or cycle limit
	logic [15:0] stepExp[$];

	// VRAM reference model
	logic [15:0]        modelMem [0:(1 << VRAM_AW) - 1];
	logic [VRAM_AW-1:0] modelAddr;
	logic [15:0]        modelMod;

	integer seed;
	int     cycleCount;
	int     timeoutLimit;

	lspcClock #(.PERIOD(40)) uClock (.clk(CLK_24M));

	lspcTop #(
		.VRAM_AW(VRAM_AW), .PIXEL_DIV(PIXEL_DIV), .LINE_PIXELS(LINE_PIXELS),
		.FRAME_LINES(FRAME_LINES), .VBLANK_LINE(VBLANK_LINE)
	) UUT (
		.CLK_24M, .nRESET,
		.cpuValid, .cpuWrite, .cpuAddr, .cpuWrData,
		.cpuReady, .cpuRdValid, .cpuRdData,
		.irqLevel, .vcount
	);

	bind lspcTop lspcTb_chk uChk (.CLK_24M, .nRESET, .cpuReady, .cpuRdValid, .irqLevel);

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1);
	endtask

	// Appends an entry, keeps the model in step with writes
	task automatic addStep(input string name, input stepOp_e op, input logic [2:0] off,
		input logic [15:0] data, input logic [15:0] exp);
		stepName.push_back(name);
		stepOp.push_back(op);
		stepOff.push_back(off);
		stepData.push_back(data);
		stepExp.push_back(exp);
		if (op == OP_WRITE)
		begin
			if (off == lspcPkg::REG_VRAM_MOD)
				modelMod = data;
			else if (off == lspcPkg::REG_VRAM_ADDR)
				modelAddr = data[VRAM_AW-1:0];
			else if (off == lspcPkg::REG_VRAM_DATA)
			begin
				modelMem[modelAddr] = data;
				modelAddr = modelAddr + modelMod[VRAM_AW-1:0];	// Unsigned step, wraps
			end
		end
	endtask

	task automatic buildTable();
		logic [15:0]        words [0:7];
		logic [VRAM_AW-1:0] fastAddr;
		logic [VRAM_AW-1:0] slowAddr;
		logic [15:0]        modeOnWrite;
		logic [15:0]        modeAtVblank;
		modeOnWrite  = 16'((1 << (lspcPkg::MODE_TMODE_LSB + lspcPkg::TMODE_RELOAD_ON_WRITE))
			| (1 << lspcPkg::MODE_TIMER_INT_EN));
		modeAtVblank = 16'((1 << (lspcPkg::MODE_TMODE_LSB + lspcPkg::TMODE_RELOAD_AT_VBLANK))
			| (1 << lspcPkg::MODE_TIMER_INT_EN));
		for (int i = 0; i < 8; i++)
			words[i] = 16'($random(seed));
		addStep("coldBootLevel", OP_WAIT_LEVEL, 3'd0, 16'd1, 16'd3);
		addStep("coldBootAck", OP_WRITE, lspcPkg::REG_IRQ_ACK, 16'h0004, 16'd0);
		addStep("coldBootClear", OP_WAIT_LEVEL, 3'd0, 16'd4, 16'd0);
		addStep("timerStopWrite", OP_WRITE, lspcPkg::REG_TIMER_STOP, 16'h0001, 16'd0);
		addStep("timerStopRead", OP_READ, lspcPkg::REG_TIMER_STOP, 16'd0, 16'd0);	// Reads 0
		addStep("modWrite", OP_WRITE, lspcPkg::REG_VRAM_MOD, 16'h0023, 16'd0);
		addStep("modRead", OP_READ, lspcPkg::REG_VRAM_MOD, 16'd0, 16'h0023);
		// Back-to-back burst, wraps past the top
		addStep("fastAddr", OP_WRITE, lspcPkg::REG_VRAM_ADDR, 16'h00F0, 16'd0);
		for (int i = 0; i < 8; i++)
			addStep("fastWrite", OP_WRITE, lspcPkg::REG_VRAM_DATA, words[i], 16'd0);
		// Same words with idle gaps
		addStep("slowAddr", OP_WRITE, lspcPkg::REG_VRAM_ADDR, 16'h0040, 16'd0);
		for (int i = 0; i < 8; i++)
		begin
			addStep("slowGap", OP_WAIT_CYCLES, 3'd0, 16'd4, 16'd0);
			addStep("slowWrite", OP_WRITE, lspcPkg::REG_VRAM_DATA, words[i], 16'd0);
		end
		fastAddr = VRAM_AW'(8'hF0);
		slowAddr = VRAM_AW'(8'h40);
		for (int i = 0; i < 8; i++)
		begin
			addStep("fastSeek", OP_WRITE, lspcPkg::REG_VRAM_ADDR, 16'(fastAddr), 16'd0);
			addStep("fastRead", OP_READ, lspcPkg::REG_VRAM_ADDR, 16'd0, modelMem[modelAddr]);
			addStep("slowSeek", OP_WRITE, lspcPkg::REG_VRAM_ADDR, 16'(slowAddr), 16'd0);
			addStep("slowRead", OP_READ, lspcPkg::REG_VRAM_DATA, 16'd0, modelMem[modelAddr]);
			fastAddr = fastAddr + modelMod[VRAM_AW-1:0];
			slowAddr = slowAddr + modelMod[VRAM_AW-1:0];
		end
		// Line count at vblank
		addStep("vblankFlush", OP_WRITE, lspcPkg::REG_IRQ_ACK, 16'h0001, 16'd0);
		addStep("vblankIdle", OP_WAIT_LEVEL, 3'd0, 16'd4, 16'd0);
		addStep("vblankLevel", OP_WAIT_LEVEL, 3'd0, 16'(LVL_LIMIT), 16'd1);
		addStep("vblankLine", OP_READ, lspcPkg::REG_MODE, 16'd0, 16'(VBLANK_LINE << 7));
		addStep("vblankAck", OP_WRITE, lspcPkg::REG_IRQ_ACK, 16'h0001, 16'd0);
		addStep("vblankClear", OP_WAIT_LEVEL, 3'd0, 16'd4, 16'd0);
		// Timer of 5, reload on write
		addStep("timerMode", OP_WRITE, lspcPkg::REG_MODE, modeOnWrite, 16'd0);
		addStep("timerHigh", OP_WRITE, lspcPkg::REG_TIMER_HIGH, 16'd0, 16'd0);
		addStep("timerLow", OP_WRITE, lspcPkg::REG_TIMER_LOW, 16'd5, 16'd0);
		addStep("timerLevel", OP_WAIT_LEVEL, 3'd0, 16'(TICK_LIMIT), 16'd2);
		addStep("timerAck", OP_WRITE, lspcPkg::REG_IRQ_ACK, 16'h0002, 16'd0);
		addStep("timerClear", OP_WAIT_LEVEL, 3'd0, 16'd4, 16'd0);
		// Reload at vblank gives both sources pending
		addStep("bothMode", OP_WRITE, lspcPkg::REG_MODE, modeAtVblank, 16'd0);
		addStep("bothVblank", OP_WAIT_LEVEL, 3'd0, 16'(LVL_LIMIT), 16'd1);
		addStep("bothTimer", OP_WAIT_LEVEL, 3'd0, 16'(TICK_LIMIT), 16'd2);
		addStep("bothAckTimer", OP_WRITE, lspcPkg::REG_IRQ_ACK, 16'h0002, 16'd0);
		addStep("bothLeft", OP_WAIT_LEVEL, 3'd0, 16'd4, 16'd1);
		addStep("bothAckVblank", OP_WRITE, lspcPkg::REG_IRQ_ACK, 16'h0001, 16'd0);
		addStep("bothClear", OP_WAIT_LEVEL, 3'd0, 16'd4, 16'd0);
	endtask

	// Holds the request until taken, then drops it
	task automatic issueRequest(input logic write, input logic [2:0] off, input logic [15:0] data);
		int stall;
		stall     = 0;
		cpuValid  = 1'b1;
		cpuWrite  = write;
		cpuAddr   = off;
		cpuWrData = data;
		@(negedge CLK_24M);
		while (!cpuReady)
		begin
			stall++;
			@(negedge CLK_24M);
		end
		assert (stall <= 2)
		else
			failRun("cpuReady held low for more than two cycles");
		@(posedge CLK_24M);
		#1;
		cpuValid = 1'b0;
		cpuWrite = 1'b0;
	endtask

	task automatic applyStep(input int i);
		logic [15:0] got;
		int          n;
		case (stepOp[i])
			OP_WRITE: issueRequest(1'b1, stepOff[i], stepData[i]);
			OP_READ:
			begin
				issueRequest(1'b0, stepOff[i], 16'd0);
				@(negedge CLK_24M);
				while (!cpuRdValid)
					@(negedge CLK_24M);
				got = cpuRdData;	// Mid-cycle, settled
				assert (got === stepExp[i])
				else
					failRun($sformatf("error %s: expected %h, actual %h",
						stepName[i], stepExp[i], got));
				// Mode word carries the line count in its top nine bits
				if (stepOff[i] == lspcPkg::REG_MODE)
				begin
					assert (vcount === stepExp[i][15:7])
					else
						failRun($sformatf("error %s: expected vcount %0d, actual %0d",
							stepName[i], stepExp[i][15:7], vcount));
				end
				@(posedge CLK_24M);
				#1;
			end
			OP_WAIT_LEVEL:
			begin
				n = 0;
				@(negedge CLK_24M);
				while ((irqLevel !== stepExp[i][1:0]) && (n < int'(stepData[i])))
				begin
					n++;
					@(negedge CLK_24M);
				end
				assert (irqLevel === stepExp[i][1:0])
				else
					failRun($sformatf("%s: irqLevel did not reach %0d within %0d cycles",
						stepName[i], stepExp[i][1:0], stepData[i]));
				@(posedge CLK_24M);
				#1;
			end
			default:
			begin
				repeat (stepData[i]) @(posedge CLK_24M);
				#1;
			end
		endcase
	endtask

	// Run limit
	always @(posedge CLK_24M)
	begin
		cycleCount = cycleCount + 1;
		assert (cycleCount < timeoutLimit)
		else
			failRun("Run did not finish within the cycle limit");
	end

	initial
	begin
		cpuValid     = 1'b0;
		cpuWrite     = 1'b0;
		cpuAddr      = 3'd0;
		cpuWrData    = 16'd0;
		nRESET       = 1'b0;
		cycleCount   = 0;
		seed         = 32'h85ba;
		modelAddr    = '0;
		modelMod     = '0;
		timeoutLimit = 1000;	// Replaced once the table length is known
		buildTable();
		timeoutLimit = stepName.size() * FRAME_CLKS + 500;	// Each entry at most a frame
		repeat (8) @(posedge CLK_24M);
		#1;
		nRESET = 1'b1;
		for (int i = 0; i < stepName.size(); i++)
			applyStep(i);
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

/* test/lspcTb_chk.sv */
`timescale 1ns/10ps
`default_nettype none

// Bound into lspcTop, watches the CPU side
module lspcTb_chk (
	input wire logic       CLK_24M,
	input wire logic       nRESET,
	input wire logic       cpuReady,
	input wire logic       cpuRdValid,
	input wire logic [1:0] irqLevel
);

	// Read return is a single-cycle pulse
	rdValidPulse: assert property (@(posedge CLK_24M) disable iff (!nRESET)
		cpuRdValid |=> !cpuRdValid)
	else
		$error("cpuRdValid high for two cycles in a row");

	// Level fully defined once out of reset
	irqLevelKnown: assert property (@(posedge CLK_24M) disable iff (!nRESET)
		!$isunknown(irqLevel))
	else
		$error("irqLevel unknown after reset");

	// VRAM busy window is two cycles
	readyRecovers: assert property (@(posedge CLK_24M) disable iff (!nRESET)
		$fell(cpuReady) |-> ##[1:3] cpuReady)
	else
		$error("cpuReady stayed low longer than 3 cycles");

endmodule

`default_nettype wire

/* test/lspcClock.sv */
`timescale 1ns/10ps
`default_nettype none

// Free-running testbench clock
module lspcClock #(
	parameter int PERIOD = 40
) (
	output logic clk
);

	initial
		clk = 1'b0;

	always #(PERIOD / 2) clk = ~clk;	// Half period per phase

endmodule

`default_nettype wire

/* verilog/lspcTop.sv */
`timescale 1ns/10ps
`default_nettype none

module lspcTop #(
	parameter int VRAM_AW     = 8,
	parameter int PIXEL_DIV   = 4,
	parameter int LINE_PIXELS = 4,
	parameter int FRAME_LINES = 24,
	parameter int VBLANK_LINE = 20
) (
	input  wire logic        CLK_24M,
	input  wire logic        nRESET,
	input  wire logic        cpuValid,
	input  wire logic        cpuWrite,
	input  wire logic [2:0]  cpuAddr,	// Word offset
	input  wire logic [15:0] cpuWrData,
	output logic             cpuReady,
	output logic             cpuRdValid,
	output logic [15:0]      cpuRdData,
	output logic [1:0]       irqLevel,	// 0 when nothing pending
	output logic [8:0]       vcount
);

	logic [31:0] timerLoad;
	logic [2:0]  timerMode;
	logic        timerIntEn;
	logic        reloadPulse;
	logic        ackValid;
	logic [2:0]  ackBits;
	logic        vblankEvent;
	logic        timerEvent;

	vramPortIf vramBus ();

	lspcRegs uRegs (
		.CLK_24M, .nRESET,
		.cpuValid, .cpuWrite, .cpuAddr, .cpuWrData,
		.cpuReady, .cpuRdValid, .cpuRdData,
		.vram (vramBus.requester),
		.vcount,
		.timerLoad, .timerMode, .timerIntEn, .reloadPulse,
		.ackValid, .ackBits
	);

	lspcVram #(.VRAM_AW(VRAM_AW)) uVram (
		.CLK_24M, .nRESET,
		.vram (vramBus.port)
	);

	lspcRaster #(
		.PIXEL_DIV(PIXEL_DIV), .LINE_PIXELS(LINE_PIXELS),
		.FRAME_LINES(FRAME_LINES), .VBLANK_LINE(VBLANK_LINE)
	) uRaster (
		.CLK_24M, .nRESET,
		.timerLoad, .timerMode, .timerIntEn, .reloadPulse,
		.vcount, .vblankEvent, .timerEvent
	);

	lspcIrq uIrq (
		.CLK_24M, .nRESET,
		.vblankEvent, .timerEvent,
		.ackValid, .ackBits,
		.irqLevel
	);

endmodule

`default_nettype wire

/* verilog/lspcIrq.sv */
`timescale 1ns/10ps
`default_nettype none

module lspcIrq (
	input  wire logic       CLK_24M,
	input  wire logic       nRESET,
	input  wire logic       vblankEvent,
	input  wire logic       timerEvent,
	input  wire logic       ackValid,
	input  wire logic [2:0] ackBits,
	output logic [1:0]      irqLevel
);

	logic [2:0] pending;
	logic [2:0] setBits;
	logic [2:0] clrBits;

	always_comb
	begin
		setBits                        = '0;
		setBits[lspcPkg::IRQ_VBLANK]   = vblankEvent;
		setBits[lspcPkg::IRQ_TIMER]    = timerEvent;
		setBits[lspcPkg::IRQ_COLDBOOT] = 1'b0;	// Only reset raises it
	end

	assign clrBits = ackValid ? ackBits : 3'b000;

	// Set beats ack in the same cycle
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
			pending <= 3'b100;	// Cold boot pending out of reset
		else
			pending <= setBits | (pending & ~clrBits);
	end

	// Highest pending level wins
	always_comb
	begin
		if (pending[lspcPkg::IRQ_COLDBOOT])
			irqLevel = 2'd3;
		else if (pending[lspcPkg::IRQ_TIMER])
			irqLevel = 2'd2;
		else if (pending[lspcPkg::IRQ_VBLANK])
			irqLevel = 2'd1;
		else
			irqLevel = 2'd0;
	end

endmodule

`default_nettype wire

/* verilog/lspcRaster.sv */
`timescale 1ns/10ps
`default_nettype none

module lspcRaster #(
	parameter int PIXEL_DIV   = 4,
	parameter int LINE_PIXELS = 4,
	parameter int FRAME_LINES = 24,
	parameter int VBLANK_LINE = 20
) (
	input  wire logic        CLK_24M,
	input  wire logic        nRESET,
	input  wire logic [31:0] timerLoad,
	input  wire logic [2:0]  timerMode,
	input  wire logic        timerIntEn,
	input  wire logic        reloadPulse,
	output logic [8:0]       vcount,
	output logic             vblankEvent,
	output logic             timerEvent
);

	localparam int DIV_W = (PIXEL_DIV > 1) ? $clog2(PIXEL_DIV) : 1;
	localparam int PIX_W = (LINE_PIXELS > 1) ? $clog2(LINE_PIXELS) : 1;

	logic [DIV_W-1:0] divCnt;
	logic [PIX_W-1:0] pixCnt;
	logic             pixTick;
	logic             lineEnd;
	logic [8:0]       nextLine;
	logic             vblankHit;
	logic [31:0]      timer;
	logic             timerHit;

	assign pixTick   = (divCnt == DIV_W'(PIXEL_DIV - 1));
	assign lineEnd   = pixTick && (pixCnt == PIX_W'(LINE_PIXELS - 1));
	assign nextLine  = (vcount == 9'(FRAME_LINES - 1)) ? 9'd0 : vcount + 9'd1;
	assign vblankHit = lineEnd && (nextLine == 9'(VBLANK_LINE));
	assign timerHit  = pixTick && (timer == 32'd1);	// Count hits zero this tick

	// Pixel divider and line counter
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			divCnt      <= '0;
			pixCnt      <= '0;
			vcount      <= '0;
			vblankEvent <= 1'b0;
		end
		else
		begin
			divCnt      <= pixTick ? '0 : divCnt + 1'b1;
			vblankEvent <= vblankHit;	// High while vcount first shows VBLANK_LINE
			if (pixTick)
				pixCnt <= lineEnd ? '0 : pixCnt + 1'b1;
			if (lineEnd)
				vcount <= nextLine;
		end
	end

	// Pixel timer
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			timer      <= '0;
			timerEvent <= 1'b0;
		end
		else
		begin
			timerEvent <= timerHit && timerIntEn;
			if (reloadPulse && timerMode[lspcPkg::TMODE_RELOAD_ON_WRITE])
				timer <= timerLoad;
			else if (vblankHit && timerMode[lspcPkg::TMODE_RELOAD_AT_VBLANK])
				timer <= timerLoad;
			else if (timerHit && timerMode[lspcPkg::TMODE_RELOAD_AT_ZERO])
				timer <= timerLoad;
			else if (pixTick && (timer != 32'd0))
				timer <= timer - 32'd1;	// Stops at zero otherwise
		end
	end

endmodule

`default_nettype wire

/* verilog/lspcVram.sv */
`timescale 1ns/10ps
`default_nettype none

module lspcVram #(
	parameter int VRAM_AW = 8
) (
	input  wire logic CLK_24M,
	input  wire logic nRESET,
	vramPortIf.port   vram
);

	logic [15:0]          mem [0:(1 << VRAM_AW) - 1];
	logic [VRAM_AW-1:0]   addr;	// Current CPU VRAM pointer
	lspcPkg::vramState_e  state;
	lspcPkg::vramOp_e     opLatch;
	logic [15:0]          dataLatch;
	logic                 opAccept;

	assign vram.opReady = (state == lspcPkg::VST_IDLE);
	assign opAccept     = vram.opValid && vram.opReady && (vram.op != lspcPkg::VOP_NONE);

	// Request capture
	always_ff @(posedge CLK_24M)
	begin
		if (opAccept)
		begin
			opLatch   <= vram.op;
			dataLatch <= vram.wrData;
		end
	end

	// Array write, one cycle after acceptance
	always_ff @(posedge CLK_24M)
	begin
		if ((state == lspcPkg::VST_WRITE) && (opLatch == lspcPkg::VOP_WRITE))
			mem[addr] <= dataLatch;
	end

	// Idle, then address update, then prefetch
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			state         <= lspcPkg::VST_IDLE;
			addr          <= '0;
			vram.rdBuffer <= '0;
		end
		else
		begin
			case (state)
				lspcPkg::VST_IDLE:
				begin
					if (opAccept)
						state <= lspcPkg::VST_WRITE;
				end
				lspcPkg::VST_WRITE:
				begin
					if (opLatch == lspcPkg::VOP_WRITE)
						addr <= addr + vram.modulo[VRAM_AW-1:0];	// Unsigned, wraps
					else
						addr <= dataLatch[VRAM_AW-1:0];	// Set address
					state <= lspcPkg::VST_PREFETCH;
				end
				lspcPkg::VST_PREFETCH:
				begin
					vram.rdBuffer <= mem[addr];	// New pointer already in place
					state         <= lspcPkg::VST_IDLE;
				end
				default: state <= lspcPkg::VST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/lspcRegs.sv */
`timescale 1ns/10ps
`default_nettype none

module lspcRegs (
	input  wire logic        CLK_24M,
	input  wire logic        nRESET,
	input  wire logic        cpuValid,
	input  wire logic        cpuWrite,
	input  wire logic [2:0]  cpuAddr,
	input  wire logic [15:0] cpuWrData,
	output logic             cpuReady,
	output logic             cpuRdValid,
	output logic [15:0]      cpuRdData,
	vramPortIf.requester     vram,
	input  wire logic [8:0]  vcount,
	output logic [31:0]      timerLoad,
	output logic [2:0]       timerMode,
	output logic             timerIntEn,
	output logic             reloadPulse,
	output logic             ackValid,
	output logic [2:0]       ackBits
);

	lspcPkg::regAddr_e reqAddr;
	logic              isVramReg;
	logic              wrAccept;
	logic              rdAccept;
	logic [15:0]       vramMod;
	logic              timerStop;	// PAL timer stop, no effect here
	logic [15:0]       rdMux;

	assign reqAddr   = lspcPkg::regAddr_e'(cpuAddr);
	assign isVramReg = (reqAddr == lspcPkg::REG_VRAM_ADDR) ||
		(reqAddr == lspcPkg::REG_VRAM_DATA);

	// Only VRAM offsets can stall
	assign cpuReady = isVramReg ? vram.opReady : 1'b1;
	assign wrAccept = cpuValid && cpuReady && cpuWrite;
	assign rdAccept = cpuValid && cpuReady && !cpuWrite;

	// VRAM writes pass straight to the port
	assign vram.opValid = cpuValid && cpuWrite && isVramReg;
	assign vram.wrData  = cpuWrData;
	assign vram.modulo  = vramMod;
	always_comb
	begin
		if (!(cpuWrite && isVramReg))
			vram.op = lspcPkg::VOP_NONE;
		else if (reqAddr == lspcPkg::REG_VRAM_DATA)
			vram.op = lspcPkg::VOP_WRITE;	// Store then step by modulo
		else
			vram.op = lspcPkg::VOP_SET_ADDR;
	end

	// Register storage
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			vramMod     <= '0;
			timerMode   <= '0;
			timerIntEn  <= 1'b0;
			timerLoad   <= '0;
			timerStop   <= 1'b0;
			reloadPulse <= 1'b0;
			ackValid    <= 1'b0;
		end
		else
		begin
			reloadPulse <= wrAccept && (reqAddr == lspcPkg::REG_TIMER_LOW);
			ackValid    <= wrAccept && (reqAddr == lspcPkg::REG_IRQ_ACK);
			if (wrAccept)
			begin
				case (reqAddr)
					lspcPkg::REG_VRAM_MOD:   vramMod <= cpuWrData;
					lspcPkg::REG_MODE:
					begin
						// AA speed and disable are dropped
						timerMode  <= cpuWrData[lspcPkg::MODE_TMODE_LSB +: 3];
						timerIntEn <= cpuWrData[lspcPkg::MODE_TIMER_INT_EN];
					end
					lspcPkg::REG_TIMER_HIGH: timerLoad[31:16] <= cpuWrData;
					lspcPkg::REG_TIMER_LOW:  timerLoad[15:0] <= cpuWrData;
					lspcPkg::REG_TIMER_STOP: timerStop <= cpuWrData[0];
					default: ;	// VRAM ops and ack handled elsewhere
				endcase
			end
		end
	end

	// Ack mask, one bit per source
	always_ff @(posedge CLK_24M)
	begin
		if (wrAccept && (reqAddr == lspcPkg::REG_IRQ_ACK))
		begin
			ackBits[lspcPkg::IRQ_VBLANK]   <= cpuWrData[0];
			ackBits[lspcPkg::IRQ_TIMER]    <= cpuWrData[1];
			ackBits[lspcPkg::IRQ_COLDBOOT] <= cpuWrData[2];
		end
	end

	always_comb
	begin
		case (reqAddr)
			lspcPkg::REG_VRAM_ADDR,
			lspcPkg::REG_VRAM_DATA: rdMux = vram.rdBuffer;	// Both mirror the buffer
			lspcPkg::REG_VRAM_MOD:  rdMux = vramMod;
			lspcPkg::REG_MODE:      rdMux = {vcount, 7'd0};	// Video mode and AA count read 0
			default:                rdMux = 16'd0;
		endcase
	end

	// Read data one cycle after acceptance
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
			cpuRdValid <= 1'b0;
		else
			cpuRdValid <= rdAccept;
	end

	always_ff @(posedge CLK_24M)
	begin
		if (rdAccept)
			cpuRdData <= rdMux;
	end

endmodule

`default_nettype wire

/* verilog/vramPortIf.sv */
`timescale 1ns/10ps
`default_nettype none

// Register block to VRAM port link
interface vramPortIf;
	logic                opValid;
	lspcPkg::vramOp_e    op;
	logic [15:0]         wrData;
	logic [15:0]         modulo;	// Lives in the register block
	logic                opReady;
	logic [15:0]         rdBuffer;	// Prefetched word at current address

	modport requester (
		output opValid, op, wrData, modulo,
		input  opReady, rdBuffer
	);

	modport port (
		input  opValid, op, wrData, modulo,
		output opReady, rdBuffer
	);

endinterface

`default_nettype wire

/* verilog/lspcPkg.sv */
`default_nettype none

package lspcPkg;

	// CPU word offsets, $3C0000 up in steps of 2
	typedef enum logic [2:0] {
		REG_VRAM_ADDR  = 3'd0,	// Set VRAM address
		REG_VRAM_DATA  = 3'd1,	// VRAM data, auto-increment
		REG_VRAM_MOD   = 3'd2,	// VRAM modulo
		REG_MODE       = 3'd3,	// LSPC mode, reads back vcount
		REG_TIMER_HIGH = 3'd4,	// Timer reload MSW
		REG_TIMER_LOW  = 3'd5,	// Timer reload LSW
		REG_IRQ_ACK    = 3'd6,	// Interrupt ack
		REG_TIMER_STOP = 3'd7	// PAL timer stop
	} regAddr_e;

	// Requests from the register block to the VRAM port
	typedef enum logic [1:0] {
		VOP_NONE     = 2'd0,
		VOP_SET_ADDR = 2'd1,
		VOP_WRITE    = 2'd2
	} vramOp_e;

	typedef enum logic [1:0] {
		VST_IDLE     = 2'd0,
		VST_WRITE    = 2'd1,	// Store and address step
		VST_PREFETCH = 2'd2	// Refill read buffer
	} vramState_e;

	// Pending bit index, level is index + 1
	typedef enum logic [1:0] {
		IRQ_VBLANK   = 2'd0,
		IRQ_TIMER    = 2'd1,
		IRQ_COLDBOOT = 2'd2
	} irqSrc_e;

	// Bits inside the 3-bit timer mode field
	localparam int TMODE_RELOAD_ON_WRITE  = 0;
	localparam int TMODE_RELOAD_AT_VBLANK = 1;
	localparam int TMODE_RELOAD_AT_ZERO   = 2;

	// Field positions in the mode word
	localparam int MODE_TMODE_LSB    = 5;
	localparam int MODE_TIMER_INT_EN = 4;

endpackage

`default_nettype wire
